/* build.f */
+incdir+design
design/spi_hub_pkg.sv
design/wb_lane_dispatch.sv
design/spi_lane.sv
design/rx_collect.sv
design/spi_hub.sv
tb/spi_hub_checker.sv
tb/spi_hub_tb.sv

/* design/rx_collect.sv */
// Per-lane reply holding with rx_valid and overrun; read data lags the request by one cycle.
`include "spi_hub_config.svh"

module rx_collect (
    input  logic                   cs,
    input  logic                   sck,
    input  spi_hub_pkg::lane_rsp_t rsp_i [`SPI_HUB_LANES],
    input  spi_hub_pkg::rd_req_t   rd_req_i,
    output logic [`SPI_HUB_DW-1:0] rd_data_o
);
    import spi_hub_pkg::*;

    logic [7:0]                hold_q [`SPI_HUB_LANES];
    logic [`SPI_HUB_LANES-1:0] valid_q;
    logic [`SPI_HUB_LANES-1:0] ovr_q;
    logic [`SPI_HUB_LANES-1:0] rx_clear;
    logic [`SPI_HUB_LANES-1:0] busy;
    logic [`SPI_HUB_DW-1:0]    rd_mux;
    logic [`SPI_HUB_DW-1:0]    rd_data_q;

    for (genvar g = 0; g < `SPI_HUB_LANES; g++) begin : g_lane
        // Reading RX consumes the held byte.
        assign rx_clear[g] = rd_req_i.valid && (rd_req_i.sel == REG_RX)
                             && (rd_req_i.lane == lane_idx_t'(g));

        assign busy[g] = rsp_i[g].busy;

        always_ff @(posedge cs) begin
            if (rsp_i[g].done) begin
                hold_q[g] <= rsp_i[g].data;
            end
        end

        // A new byte over an unread one flags overrun.
        // If the old byte is read on that same cycle, it was not lost.
        always_ff @(posedge cs or negedge sck) begin
            if (!sck) begin
                valid_q[g] <= 1'b0;
                ovr_q[g]   <= 1'b0;
            end else if (rsp_i[g].done) begin
                valid_q[g] <= 1'b1;
                ovr_q[g]   <= (valid_q[g] && !rx_clear[g]) || (ovr_q[g] && !rx_clear[g]);
            end else if (rx_clear[g]) begin
                valid_q[g] <= 1'b0;
                ovr_q[g]   <= 1'b0;
            end
        end
    end

    always_comb begin
        rd_mux = '0;
        case (rd_req_i.sel)
            REG_RX: begin
                rd_mux[7:0] = hold_q[rd_req_i.lane];
            end
            REG_STATUS: begin
                rd_mux[2:0] = {ovr_q[rd_req_i.lane], valid_q[rd_req_i.lane],
                               busy[rd_req_i.lane]};
            end
            default: begin
                rd_mux = '0;
            end
        endcase
    end

    // Loaded on the edge that raises ack, so data and ack line up.
    always_ff @(posedge cs) begin
        if (rd_req_i.valid) begin
            rd_data_q <= rd_mux;
        end
    end

    assign rd_data_o = rd_data_q;

endmodule

/* design/spi_hub.sv */
// Four-lane SPI mode 0 hub on Wishbone classic; lanes run independently with fixed timing.
`include "spi_hub_config.svh"

module spi_hub (
    input  logic                      cs,
    input  logic                      sck,
    input  spi_hub_pkg::wb_req_t      wb_req_i,
    input  logic [`SPI_HUB_LANES-1:0] spi_sd_i,
    output spi_hub_pkg::wb_rsp_t      wb_rsp_o,
    output logic [`SPI_HUB_LANES-1:0] spi_sck_o,
    output logic [`SPI_HUB_LANES-1:0] spi_cs_n_o,
    output logic [`SPI_HUB_LANES-1:0] spi_sd_o
);
    import spi_hub_pkg::*;

    lane_cmd_t              cmd [`SPI_HUB_LANES];
    lane_rsp_t              rsp [`SPI_HUB_LANES];
    rd_req_t                rd_req;
    logic                   ack;
    logic [`SPI_HUB_DW-1:0] rd_data;

    // Ack from the dispatcher, data from the collector.
    // Both are registered on the same edge.
    assign wb_rsp_o = '{ack: ack, dat: rd_data};

    wb_lane_dispatch u_dispatch (
        .cs       (cs),
        .sck      (sck),
        .wb_req_i (wb_req_i),
        .ack_o    (ack),
        .cmd_o    (cmd),
        .rd_req_o (rd_req)
    );

    // One controller per lane with its own pins.
    for (genvar g = 0; g < `SPI_HUB_LANES; g++) begin : g_lane
        spi_lane u_lane (
            .cs         (cs),
            .sck        (sck),
            .cmd_i      (cmd[g]),
            .spi_sd_i   (spi_sd_i[g]),
            .rsp_o      (rsp[g]),
            .spi_sck_o  (spi_sck_o[g]),
            .spi_cs_n_o (spi_cs_n_o[g]),
            .spi_sd_o   (spi_sd_o[g])
        );
    end

    rx_collect u_collect (
        .cs        (cs),
        .sck       (sck),
        .rsp_i     (rsp),
        .rd_req_i  (rd_req),
        .rd_data_o (rd_data)
    );

endmodule

/* design/spi_hub_config.svh */
// Hub build constants; lanes must be a power of two that fits in address bits above bit 1.
`ifndef SPI_HUB_CONFIG_SVH
`define SPI_HUB_CONFIG_SVH

// Number of independent SPI lanes.
`define SPI_HUB_LANES 4

// System clock cycles per SCK half period.
// Must be at least 2 so the divider counter has a width.
`define SPI_HUB_CLK_DIV 4

// Wishbone address width.
// Bits 1:0 pick the register and the bits above pick the lane.
`define SPI_HUB_AW 4

// Wishbone data width, at least one SPI byte.
`define SPI_HUB_DW 8

`endif

/* design/spi_hub_pkg.sv */
// Shared hub types; the lane field width follows the lane count and must match the address split.
`include "spi_hub_config.svh"

package spi_hub_pkg;

    // Register offsets inside one lane's window.
    typedef enum logic [1:0] {
        REG_TX      = 2'd0,
        REG_TX_HOLD = 2'd1,
        REG_RX      = 2'd2,
        REG_STATUS  = 2'd3
    } reg_sel_e;

    typedef logic [$clog2(`SPI_HUB_LANES)-1:0] lane_idx_t;

    // Wishbone classic request from the host.
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`SPI_HUB_AW-1:0] adr;
        logic [`SPI_HUB_DW-1:0] dat;
    } wb_req_t;

    // Wishbone classic response, data valid with ack.
    typedef struct packed {
        logic                   ack;
        logic [`SPI_HUB_DW-1:0] dat;
    } wb_rsp_t;

    // One command to a lane. Start is a single cycle pulse.
    typedef struct packed {
        logic       start;
        logic       hold;
        logic [7:0] data;
    } lane_cmd_t;

    // Lane report. Data is the last received byte.
    typedef struct packed {
        logic       done;
        logic       busy;
        logic [7:0] data;
    } lane_rsp_t;

    // Read request toward the collector.
    typedef struct packed {
        logic      valid;
        lane_idx_t lane;
        reg_sel_e  sel;
    } rd_req_t;

endpackage

/* design/spi_lane.sv */
// SPI mode 0 controller, one byte per start; the last SCK high phase is one cycle long.
`include "spi_hub_config.svh"

module spi_lane (
    input  logic                   cs,
    input  logic                   sck,
    input  spi_hub_pkg::lane_cmd_t cmd_i,
    input  logic                   spi_sd_i,
    output spi_hub_pkg::lane_rsp_t rsp_o,
    output logic                   spi_sck_o,
    output logic                   spi_cs_n_o,
    output logic                   spi_sd_o
);
    localparam int DIV_W = $clog2(`SPI_HUB_CLK_DIV);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SPI_HUB_CLK_DIV - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACTIVE,
        ST_TAIL,
        ST_HELD
    } lane_state_e;

    lane_state_e      state_q;
    logic [DIV_W-1:0] div_q;
    logic [2:0]       bit_q;
    logic             sck_q;
    logic             cs_n_q;
    logic             sd_q;
    logic             hold_q;
    logic             done_q;
    logic [7:0]       shreg_q;
    logic             busy;
    logic             load;
    logic             tick;
    logic             rise;

    assign busy = (state_q == ST_ACTIVE) || (state_q == ST_TAIL);

    // Starts that land while a byte is in flight are dropped here.
    assign load = cmd_i.start && !busy;

    assign tick = (div_q == DIV_LAST);
    assign rise = (state_q == ST_ACTIVE) && tick && !sck_q;

    // One shift register carries both directions.
    // After rise k its MSB holds the bit to show on the next fall.
    always_ff @(posedge cs) begin
        if (load) begin
            shreg_q <= cmd_i.data;
        end else if (rise) begin
            shreg_q <= {shreg_q[6:0], spi_sd_i};
        end
    end

    always_ff @(posedge cs or negedge sck) begin
        if (!sck) begin
            state_q <= ST_IDLE;
            div_q   <= '0;
            bit_q   <= '0;
            sck_q   <= 1'b0;
            cs_n_q  <= 1'b1;
            sd_q    <= 1'b0;
            hold_q  <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (load) begin
                // From HELD chip select is already low and simply stays so.
                state_q <= ST_ACTIVE;
                div_q   <= '0;
                bit_q   <= '0;
                cs_n_q  <= 1'b0;
                sd_q    <= cmd_i.data[7];
                hold_q  <= cmd_i.hold;
            end else begin
                case (state_q)
                    ST_ACTIVE: begin
                        if (tick) begin
                            div_q <= '0;
                            sck_q <= ~sck_q;
                            if (!sck_q) begin
                                bit_q <= bit_q + 3'd1;
                                // Eighth rise closes the byte.
                                if (bit_q == 3'd7) begin
                                    state_q <= ST_TAIL;
                                    done_q  <= 1'b1;
                                end
                            end else begin
                                sd_q <= shreg_q[7];
                            end
                        end else begin
                            div_q <= div_q + 1'b1;
                        end
                    end
                    ST_TAIL: begin
                        if (sck_q) begin
                            // SCK back low one cycle after the last rise.
                            sck_q <= 1'b0;
                            div_q <= '0;
                            if (hold_q) begin
                                state_q <= ST_HELD;
                            end
                        end else if (tick) begin
                            cs_n_q  <= 1'b1;
                            state_q <= ST_IDLE;
                        end else begin
                            div_q <= div_q + 1'b1;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    assign rsp_o = '{done: done_q, busy: busy, data: shreg_q};

    assign spi_sck_o  = sck_q;
    assign spi_cs_n_o = cs_n_q;
    assign spi_sd_o   = sd_q;

endmodule

/* design/wb_lane_dispatch.sv */
// Wishbone classic slave with a fixed one-cycle ack; no wait states, no err or retry.
`include "spi_hub_config.svh"

module wb_lane_dispatch (
    input  logic                   cs,
    input  logic                   sck,
    input  spi_hub_pkg::wb_req_t   wb_req_i,
    output logic                   ack_o,
    output spi_hub_pkg::lane_cmd_t cmd_o [`SPI_HUB_LANES],
    output spi_hub_pkg::rd_req_t   rd_req_o
);
    import spi_hub_pkg::*;

    logic                      ack_q;
    logic                      accept;
    logic                      tx_write;
    lane_idx_t                 lane;
    reg_sel_e                  sel;
    logic [`SPI_HUB_LANES-1:0] start_q;
    logic                      hold_q;
    logic [7:0]                data_q;

    // A request is taken once; the cycle that shows ack is not taken again.
    assign accept = wb_req_i.cyc & wb_req_i.stb & ~ack_q;

    // Upper address bits pick the lane, the low two the register.
    assign lane = lane_idx_t'(wb_req_i.adr[`SPI_HUB_AW-1:2]);
    assign sel  = reg_sel_e'(wb_req_i.adr[1:0]);

    // Only the two transmit offsets start a byte.
    // Writes to RX or STATUS fall through with just an ack.
    assign tx_write = accept & wb_req_i.we & ((sel == REG_TX) | (sel == REG_TX_HOLD));

    always_ff @(posedge cs or negedge sck) begin
        if (!sck) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= accept;
        end
    end

    // Start pulse goes to the addressed lane only, aligned with ack.
    always_ff @(posedge cs or negedge sck) begin
        if (!sck) begin
            start_q <= '0;
        end else begin
            for (int i = 0; i < `SPI_HUB_LANES; i++) begin
                start_q[i] <= tx_write && (lane == lane_idx_t'(i));
            end
        end
    end

    // Byte and hold flag are shared.
    // Each lane looks at them only with its own start.
    always_ff @(posedge cs) begin
        if (tx_write) begin
            hold_q <= (sel == REG_TX_HOLD);
            data_q <= wb_req_i.dat[7:0];
        end
    end

    for (genvar g = 0; g < `SPI_HUB_LANES; g++) begin : g_cmd
        assign cmd_o[g] = '{start: start_q[g], hold: hold_q, data: data_q};
    end

    // Read request is combinational.
    // The collector registers its answer on the edge that raises ack.
    assign rd_req_o = '{valid: accept & ~wb_req_i.we, lane: lane, sel: sel};

    assign ack_o = ack_q;

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the spi_hub simulation with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f build.f --top-module spi_hub_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vspi_hub_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
    exit 1
fi

if ! grep -q "All tests passed" "$LOG"; then
    echo "Simulation log has no final verdict"
    exit 1
fi

exit 0

/* tb/spi_hub_checker.sv */
// Watches pins and Wishbone reads; expected bytes arrive one per cycle through the push port.
`include "spi_hub_config.svh"

module spi_hub_checker (
    input  logic                            cs,
    input  logic                            sck,
    input  spi_hub_pkg::wb_req_t            wb_req_i,
    input  spi_hub_pkg::wb_rsp_t            wb_rsp_i,
    input  logic [`SPI_HUB_LANES-1:0]       spi_sck_i,
    input  logic [`SPI_HUB_LANES-1:0]       spi_cs_n_i,
    input  logic [`SPI_HUB_LANES-1:0]       spi_sd_i,
    input  logic                            exp_push_i,
    input  spi_hub_pkg::lane_idx_t          exp_lane_i,
    input  logic [7:0]                      exp_byte_i,
    input  logic                            rd_check_i,
    input  logic [`SPI_HUB_DW-1:0]          rd_exp_i,
    input  logic [`SPI_HUB_LANES-1:0][7:0]  frames_exp_i,
    input  logic                            final_i,
    output int                              err_cnt_o
);
    import spi_hub_pkg::*;

    logic [7:0]                exp_q [`SPI_HUB_LANES][$];
    logic [7:0]                shreg [`SPI_HUB_LANES];
    int                        nbits [`SPI_HUB_LANES];
    int                        frames [`SPI_HUB_LANES];
    logic [`SPI_HUB_LANES-1:0] sck_prev;
    logic [`SPI_HUB_LANES-1:0] cs_n_prev;
    logic                      req_last;
    logic                      req_new_last;
    logic                      ack_last;
    logic                      rd_pend;
    logic [`SPI_HUB_DW-1:0]    rd_exp_l;
    logic                      rst_chk_pend;
    int                        errs;
    logic [7:0]                want;

    initial begin
        errs         = 0;
        sck_prev     = '0;
        cs_n_prev    = '1;
        req_last     = 1'b0;
        req_new_last = 1'b0;
        ack_last     = 1'b0;
        rd_pend      = 1'b0;
        rd_exp_l     = '0;
        rst_chk_pend = 1'b1;
        for (int l = 0; l < `SPI_HUB_LANES; l++) begin
            nbits[l]  = 0;
            frames[l] = 0;
            shreg[l]  = '0;
        end
    end

    always @(posedge cs) begin
        if (sck) begin
            // Idle pin levels and ack on the first cycle out of reset.
            if (rst_chk_pend) begin
                rst_chk_pend = 1'b0;
                for (int l = 0; l < `SPI_HUB_LANES; l++) begin
                    if (spi_cs_n_i[l] !== 1'b1) begin
                        errs++;
                        $display("Error at time %0t: spi_cs_n_o[%0d] got %b expected 1",
                                 $time, l, spi_cs_n_i[l]);
                    end
                    if (spi_sck_i[l] !== 1'b0) begin
                        errs++;
                        $display("Error at time %0t: spi_sck_o[%0d] got %b expected 0",
                                 $time, l, spi_sck_i[l]);
                    end
                end
                if (wb_rsp_i.ack !== 1'b0) begin
                    errs++;
                    $display("Error at time %0t: wb_rsp_o.ack got %b expected 0",
                             $time, wb_rsp_i.ack);
                end
            end
            if (exp_push_i) begin
                exp_q[exp_lane_i].push_back(exp_byte_i);
            end
            for (int l = 0; l < `SPI_HUB_LANES; l++) begin
                if (spi_cs_n_i[l] && spi_sck_i[l]) begin
                    errs++;
                    $display("Lane %0d drives SCK high while chip select is high", l);
                end
                // Mode 0, data is stable at the rising edge.
                if (!spi_cs_n_i[l] && spi_sck_i[l] && !sck_prev[l]) begin
                    shreg[l] = {shreg[l][6:0], spi_sd_i[l]};
                    nbits[l]++;
                    if (nbits[l] == 8) begin
                        nbits[l] = 0;
                        if (exp_q[l].size() == 0) begin
                            errs++;
                            $display("Lane %0d sent byte %h that was never expected", l, shreg[l]);
                        end else begin
                            want = exp_q[l].pop_front();
                            if (shreg[l] !== want) begin
                                errs++;
                                $display("Error at time %0t: spi_sd_o[%0d] got %h expected %h",
                                         $time, l, shreg[l], want);
                            end
                        end
                    end
                end
                if (spi_cs_n_i[l] && !cs_n_prev[l]) begin
                    frames[l]++;
                    if (nbits[l] != 0) begin
                        errs++;
                        $display("Lane %0d ended a frame in the middle of a byte", l);
                    end
                    nbits[l] = 0;
                end
            end
            sck_prev  = spi_sck_i;
            cs_n_prev = spi_cs_n_i;

            if (wb_rsp_i.ack && !req_last) begin
                errs++;
                $display("Wishbone ack came without a request");
            end
            if (wb_rsp_i.ack && ack_last) begin
                errs++;
                $display("Wishbone ack stayed high longer than one cycle");
            end
            if (req_new_last && !wb_rsp_i.ack) begin
                errs++;
                $display("Wishbone ack did not come on the cycle after the request");
            end
            if (wb_rsp_i.ack && rd_pend && (wb_rsp_i.dat !== rd_exp_l)) begin
                errs++;
                $display("Error at time %0t: wb_rsp_o.dat got %h expected %h",
                         $time, wb_rsp_i.dat, rd_exp_l);
            end
            if (wb_rsp_i.ack) begin
                rd_pend = 1'b0;
            end
            // Latch what the read should return when it is accepted.
            if (wb_req_i.cyc && wb_req_i.stb && !wb_rsp_i.ack) begin
                rd_pend  = rd_check_i && !wb_req_i.we;
                rd_exp_l = rd_exp_i;
            end
            req_new_last = wb_req_i.cyc && wb_req_i.stb && !req_last;
            req_last     = wb_req_i.cyc && wb_req_i.stb;
            ack_last     = wb_rsp_i.ack;

            if (final_i) begin
                for (int l = 0; l < `SPI_HUB_LANES; l++) begin
                    if (frames[l] != int'(frames_exp_i[l])) begin
                        errs++;
                        $display("Error at time %0t: frames[%0d] got %0d expected %0d",
                                 $time, l, frames[l], frames_exp_i[l]);
                    end
                    if (exp_q[l].size() != 0) begin
                        errs++;
                        $display("Lane %0d never sent %0d expected bytes", l, exp_q[l].size());
                    end
                end
            end
        end
    end

    assign err_cnt_o = errs;

endmodule

/* tb/spi_hub_tb.sv */
// Table driven testbench; SPI peripherals are modelled here and sampled on the falling clock.
`include "spi_hub_config.svh"

module spi_hub_tb;
    import spi_hub_pkg::*;

    localparam logic [2:0] OP_WAIT = 3'd0;
    localparam logic [2:0] OP_TX   = 3'd1;
    localparam logic [2:0] OP_HOLD = 3'd2;
    localparam logic [2:0] OP_RX   = 3'd3;
    localparam logic [2:0] OP_STAT = 3'd4;
    localparam int N_STEPS = 44;
    localparam int LIMIT   = N_STEPS * (16 * `SPI_HUB_CLK_DIV + 60) * 2;
    localparam int MAX_POLL = 16 * `SPI_HUB_CLK_DIV + 10;

    typedef struct packed {
        logic [2:0] op;
        lane_idx_t  lane;
        logic       ign;
        logic       rnd;
        logic [7:0] tx;
        logic [7:0] reply;
        logic [7:0] exp;
    } step_t;

    // Columns: op, lane, ignored by a busy lane, random bytes, tx, reply, expected read.
    localparam step_t STEPS [N_STEPS] = '{
        '{OP_STAT, 2'd0, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00},
        '{OP_STAT, 2'd1, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00},
        '{OP_STAT, 2'd2, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00},
        '{OP_STAT, 2'd3, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00},
        '{OP_TX,   2'd0, 1'b0, 1'b0, 8'hA5, 8'h3C, 8'h00},
        '{OP_STAT, 2'd0, 1'b0, 1'b0, 8'h00, 8'h00, 8'h02},
        '{OP_RX,   2'd0, 1'b0, 1'b0, 8'h00, 8'h00, 8'h3C},
        '{OP_STAT, 2'd0, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00},
        '{OP_TX,   2'd1, 1'b0, 1'b0, 8'h81, 8'h7E, 8'h00},
        '{OP_STAT, 2'd1, 1'b0, 1'b0, 8'h00, 8'h00, 8'h02},
        '{OP_RX,   2'd1, 1'b0, 1'b0, 8'h00, 8'h00, 8'h7E},
        '{OP_STAT, 2'd1, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00},
        '{OP_TX,   2'd2, 1'b0, 1'b0, 8'h0F, 8'hC2, 8'h00},
        '{OP_STAT, 2'd2, 1'b0, 1'b0, 8'h00, 8'h00, 8'h02},
        '{OP_RX,   2'd2, 1'b0, 1'b0, 8'h00, 8'h00, 8'hC2},
        '{OP_STAT, 2'd2, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00},
        '{OP_TX,   2'd3, 1'b0, 1'b0, 8'h6D, 8'h19, 8'h00},
        '{OP_STAT, 2'd3, 1'b0, 1'b0, 8'h00, 8'h00, 8'h02},
        '{OP_RX,   2'd3, 1'b0, 1'b0, 8'h00, 8'h00, 8'h19},
        '{OP_STAT, 2'd3, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00},
        // Three bytes in one frame.
        '{OP_HOLD, 2'd2, 1'b0, 1'b0, 8'h11, 8'h81, 8'h00},
        '{OP_RX,   2'd2, 1'b0, 1'b0, 8'h00, 8'h00, 8'h81},
        '{OP_HOLD, 2'd2, 1'b0, 1'b0, 8'h22, 8'h42, 8'h00},
        '{OP_RX,   2'd2, 1'b0, 1'b0, 8'h00, 8'h00, 8'h42},
        '{OP_TX,   2'd2, 1'b0, 1'b0, 8'h33, 8'h24, 8'h00},
        '{OP_RX,   2'd2, 1'b0, 1'b0, 8'h00, 8'h00, 8'h24},
        // Second write lands while the lane is busy.
        '{OP_TX,   2'd3, 1'b0, 1'b0, 8'h5A, 8'hC3, 8'h00},
        '{OP_TX,   2'd3, 1'b1, 1'b0, 8'h96, 8'h00, 8'h00},
        '{OP_STAT, 2'd3, 1'b0, 1'b0, 8'h00, 8'h00, 8'h02},
        '{OP_RX,   2'd3, 1'b0, 1'b0, 8'h00, 8'h00, 8'hC3},
        // Overrun.
        '{OP_TX,   2'd1, 1'b0, 1'b0, 8'h0F, 8'hF0, 8'h00},
        '{OP_WAIT, 2'd1, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00},
        '{OP_TX,   2'd1, 1'b0, 1'b0, 8'hE1, 8'h1E, 8'h00},
        '{OP_STAT, 2'd1, 1'b0, 1'b0, 8'h00, 8'h00, 8'h06},
        '{OP_RX,   2'd1, 1'b0, 1'b0, 8'h00, 8'h00, 8'h1E},
        '{OP_STAT, 2'd1, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00},
        // All lanes at once with random bytes.
        '{OP_TX,   2'd0, 1'b0, 1'b1, 8'h00, 8'h00, 8'h00},
        '{OP_TX,   2'd1, 1'b0, 1'b1, 8'h00, 8'h00, 8'h00},
        '{OP_TX,   2'd2, 1'b0, 1'b1, 8'h00, 8'h00, 8'h00},
        '{OP_TX,   2'd3, 1'b0, 1'b1, 8'h00, 8'h00, 8'h00},
        '{OP_RX,   2'd0, 1'b0, 1'b1, 8'h00, 8'h00, 8'h00},
        '{OP_RX,   2'd1, 1'b0, 1'b1, 8'h00, 8'h00, 8'h00},
        '{OP_RX,   2'd2, 1'b0, 1'b1, 8'h00, 8'h00, 8'h00},
        '{OP_RX,   2'd3, 1'b0, 1'b1, 8'h00, 8'h00, 8'h00}
    };

    logic                           cs;
    logic                           sck;
    wb_req_t                        wb_req;
    wb_rsp_t                        wb_rsp;
    logic [`SPI_HUB_LANES-1:0]      spi_sd_i;
    logic [`SPI_HUB_LANES-1:0]      spi_sck_o;
    logic [`SPI_HUB_LANES-1:0]      spi_cs_n_o;
    logic [`SPI_HUB_LANES-1:0]      spi_sd_o;
    logic                           exp_push;
    lane_idx_t                      exp_lane;
    logic [7:0]                     exp_byte;
    logic                           rd_check;
    logic [`SPI_HUB_DW-1:0]         rd_exp;
    logic [`SPI_HUB_LANES-1:0][7:0] frames_exp;
    logic                           final_chk;
    int                             chk_errs;
    int                             drv_errs;
    int                             cycles;
    logic [31:0]                    lfsr;
    logic [7:0]                     last_reply [`SPI_HUB_LANES];

    // Peripheral model state.
    logic [7:0]                reply_q [`SPI_HUB_LANES][$];
    logic [7:0]                per_sh [`SPI_HUB_LANES];
    logic                      pending [`SPI_HUB_LANES];
    int                        rises [`SPI_HUB_LANES];
    logic [`SPI_HUB_LANES-1:0] sck_seen;
    logic [`SPI_HUB_LANES-1:0] cs_n_seen;

    spi_hub uut (
        .cs         (cs),
        .sck        (sck),
        .wb_req_i   (wb_req),
        .spi_sd_i   (spi_sd_i),
        .wb_rsp_o   (wb_rsp),
        .spi_sck_o  (spi_sck_o),
        .spi_cs_n_o (spi_cs_n_o),
        .spi_sd_o   (spi_sd_o)
    );

    spi_hub_checker u_checker (
        .cs           (cs),
        .sck          (sck),
        .wb_req_i     (wb_req),
        .wb_rsp_i     (wb_rsp),
        .spi_sck_i    (spi_sck_o),
        .spi_cs_n_i   (spi_cs_n_o),
        .spi_sd_i     (spi_sd_o),
        .exp_push_i   (exp_push),
        .exp_lane_i   (exp_lane),
        .exp_byte_i   (exp_byte),
        .rd_check_i   (rd_check),
        .rd_exp_i     (rd_exp),
        .frames_exp_i (frames_exp),
        .final_i      (final_chk),
        .err_cnt_o    (chk_errs)
    );

    initial cs = 1'b0;
    always #4 cs = ~cs;

    always @(posedge cs) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("Timeout after %0d cycles, the run did not finish", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    // Peripheral loads its reply at chip select fall or after the eighth rise.
    always @(negedge cs) begin
        for (int l = 0; l < `SPI_HUB_LANES; l++) begin
            if (!spi_cs_n_o[l] && cs_n_seen[l]) begin
                pending[l] = 1'b1;
                rises[l]   = 0;
            end
            if (spi_cs_n_o[l]) begin
                pending[l] = 1'b0;
            end
            if (!spi_cs_n_o[l] && spi_sck_o[l] && !sck_seen[l]) begin
                rises[l]++;
                if (rises[l] == 8) begin
                    rises[l]   = 0;
                    pending[l] = 1'b1;
                end
            end
            if (!spi_cs_n_o[l] && !spi_sck_o[l] && sck_seen[l] && !pending[l]) begin
                per_sh[l]   = {per_sh[l][6:0], 1'b0};
                spi_sd_i[l] = per_sh[l][7];
            end
            if (pending[l] && reply_q[l].size() != 0) begin
                per_sh[l]   = reply_q[l].pop_front();
                spi_sd_i[l] = per_sh[l][7];
                pending[l]  = 1'b0;
            end
        end
        sck_seen  = spi_sck_o;
        cs_n_seen = spi_cs_n_o;
    end

    // Fibonacci LFSR, taps 32 22 2 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_byte(output logic [7:0] b);
        b = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);
            b = {b[6:0], lfsr[0]};
        end
    endtask

    task automatic wb_access(input logic we, input lane_idx_t lane, input reg_sel_e sel,
                             input logic [7:0] wdat, input logic push, input logic chk,
                             input logic [7:0] exp, output logic [7:0] rdat);
        int waited;
        waited = 0;
        @(negedge cs);
        wb_req   = '{cyc: 1'b1, stb: 1'b1, we: we, adr: {lane, sel}, dat: wdat};
        exp_push = push;
        rd_check = chk;
        rd_exp   = exp;
        @(negedge cs);
        exp_push = 1'b0;
        while (!wb_rsp.ack && waited < 20) begin
            @(negedge cs);
            waited++;
        end
        if (!wb_rsp.ack) begin
            drv_errs++;
            $display("Wishbone access to lane %0d register %0d got no ack", lane, sel);
        end
        rdat     = wb_rsp.dat;
        wb_req   = '0;
        rd_check = 1'b0;
    endtask

    task automatic wait_idle(input lane_idx_t lane);
        logic [7:0] st;
        for (int n = 0; n < MAX_POLL; n++) begin
            wb_access(1'b0, lane, REG_STATUS, 8'h00, 1'b0, 1'b0, 8'h00, st);
            if (!st[0]) begin
                return;
            end
        end
        drv_errs++;
        $display("Lane %0d stayed busy too long", lane);
    endtask

    task automatic run_step(input step_t s);
        logic [7:0] tx;
        logic [7:0] reply;
        logic [7:0] exp;
        logic [7:0] rd;
        tx    = s.tx;
        reply = s.reply;
        exp   = s.exp;
        case (s.op)
            OP_TX, OP_HOLD: begin
                if (s.rnd) begin
                    draw_byte(tx);
                    draw_byte(reply);
                end
                if (!s.ign) begin
                    reply_q[s.lane].push_back(reply);
                    last_reply[s.lane] = reply;
                    // Checker push rides along with the write request.
                    exp_lane = s.lane;
                    exp_byte = tx;
                end
                wb_access(1'b1, s.lane, (s.op == OP_HOLD) ? REG_TX_HOLD : REG_TX,
                          tx, !s.ign, 1'b0, 8'h00, rd);
            end
            OP_RX: begin
                wait_idle(s.lane);
                if (s.rnd) begin
                    exp = last_reply[s.lane];
                end
                wb_access(1'b0, s.lane, REG_RX, 8'h00, 1'b0, 1'b1, exp, rd);
            end
            OP_STAT: begin
                wait_idle(s.lane);
                wb_access(1'b0, s.lane, REG_STATUS, 8'h00, 1'b0, 1'b1, exp, rd);
            end
            default: begin
                wait_idle(s.lane);
            end
        endcase
    endtask

    initial begin
        sck        = 1'b0;
        wb_req     = '0;
        spi_sd_i   = '0;
        exp_push   = 1'b0;
        exp_lane   = '0;
        exp_byte   = '0;
        rd_check   = 1'b0;
        rd_exp     = '0;
        final_chk  = 1'b0;
        drv_errs   = 0;
        cycles     = 0;
        lfsr       = 32'h117e_c060;
        frames_exp = '0;
        sck_seen   = '0;
        cs_n_seen  = '1;
        for (int l = 0; l < `SPI_HUB_LANES; l++) begin
            per_sh[l]     = '0;
            pending[l]    = 1'b0;
            rises[l]      = 0;
            last_reply[l] = '0;
        end
        // A frame closes on every plain TX that the lane accepts.
        for (int i = 0; i < N_STEPS; i++) begin
            if (STEPS[i].op == OP_TX && !STEPS[i].ign) begin
                frames_exp[STEPS[i].lane] = frames_exp[STEPS[i].lane] + 8'd1;
            end
        end
        repeat (10) @(negedge cs);
        sck = 1'b1;
        repeat (4) @(negedge cs);

        for (int i = 0; i < N_STEPS; i++) begin
            run_step(STEPS[i]);
        end
        for (int l = 0; l < `SPI_HUB_LANES; l++) begin
            wait_idle(lane_idx_t'(l));
        end
        repeat (2 * `SPI_HUB_CLK_DIV + 4) @(negedge cs);
        final_chk = 1'b1;
        @(negedge cs);
        final_chk = 1'b0;
        repeat (2) @(negedge cs);

        $display("Checker errors: %0d, driver errors: %0d", chk_errs, drv_errs);
        if (chk_errs == 0 && drv_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
